/* logic/rv_pkg.sv */
//########################################
// RV32I opcodes, control select encodings
// and the instruction format views
// Formats are fixed at 32 bits
//########################################

package rv_pkg;

  // Major opcodes, bits 6:0
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_sel_e;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scattered across the word
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, read through any format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_insn_u;

endpackage

/* logic/insn_memory.sv */
//########################################
// Addresses wrap modulo MEM_DEPTH words
// Low two address bits are ignored
// Same-word read and write returns old data
//########################################

`timescale 1ns/1ns

module insn_memory #(
  parameter int                AWIDTH    = 32,
  parameter int                DWIDTH    = 32,
  parameter logic [AWIDTH-1:0] BASE_ADDR = 32'h0100_0000,
  parameter int                MEM_DEPTH = 256
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic [AWIDTH-1:0] addr_i,
  input  logic [DWIDTH-1:0] data_i,
  input  logic              read_en_i,
  input  logic              write_en_i,
  input  logic [AWIDTH-1:0] write_addr_i,
  output logic [DWIDTH-1:0] data_o
);

  localparam int IW = $clog2(MEM_DEPTH);

  logic [DWIDTH-1:0] mem [MEM_DEPTH];
  logic [IW-1:0]     rd_idx;
  logic [IW-1:0]     wr_idx;

  // Byte address to word slot, relative to BASE_ADDR
  function automatic logic [IW-1:0] word_index(input logic [AWIDTH-1:0] byte_addr);
    logic [AWIDTH-1:0] offset;
    offset = byte_addr - BASE_ADDR;
    return IW'((offset >> 2) % MEM_DEPTH);
  endfunction

  assign rd_idx = word_index(addr_i);
  assign wr_idx = word_index(write_addr_i);

  // Load port
  always_ff @(posedge clk) begin
    if (write_en_i) begin
      mem[wr_idx] <= data_i;
    end
  end

  // Registered read, holds when not enabled
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_o <= '0;
    end else if (read_en_i) begin
      data_o <= mem[rd_idx];
    end
  end

endmodule

/* logic/fetch.sv */
//########################################
// PC starts at BASE_ADDR, steps by 4
// No redirect; run_i low is the only stall
//########################################

`timescale 1ns/1ns

module fetch #(
  parameter int                AWIDTH    = 32,
  parameter int                DWIDTH    = 32,
  parameter logic [AWIDTH-1:0] BASE_ADDR = 32'h0100_0000
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              run_i,
  input  logic [DWIDTH-1:0] insn_i,
  output logic [AWIDTH-1:0] pc_o,
  output logic              f_valid_o,
  output logic [AWIDTH-1:0] f_pc_o,
  output logic [DWIDTH-1:0] f_insn_o
);

  logic [AWIDTH-1:0] pc_q;
  logic              valid_q;
  logic [AWIDTH-1:0] pc_read_q;

  // Program counter and the valid flag of the read in flight
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q    <= BASE_ADDR;
      valid_q <= 1'b0;
    end else begin
      valid_q <= run_i;
      if (run_i) begin
        pc_q <= pc_q + AWIDTH'(4);
      end
    end
  end

  // PC of the word now on the memory output
  always_ff @(posedge clk) begin
    if (run_i) begin
      pc_read_q <= pc_q;
    end
  end

  assign pc_o      = pc_q;
  assign f_valid_o = valid_q;
  assign f_pc_o    = pc_read_q;
  assign f_insn_o  = insn_i;

endmodule

/* logic/decode.sv */
//########################################
// One register stage, loaded on valid_i
// Immediate is always sign-extended
// Unknown opcodes give a zero immediate
//########################################

`timescale 1ns/1ns

module decode #(
  parameter int AWIDTH = 32,
  parameter int DWIDTH = 32
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  logic [AWIDTH-1:0] pc_i,
  input  logic [DWIDTH-1:0] insn_i,
  output logic              valid_o,
  output logic [AWIDTH-1:0] pc_o,
  output logic [DWIDTH-1:0] insn_o,
  output logic [6:0]        opcode_o,
  output logic [4:0]        rd_o,
  output logic [4:0]        rs1_o,
  output logic [4:0]        rs2_o,
  output logic [2:0]        funct3_o,
  output logic [6:0]        funct7_o,
  output logic [DWIDTH-1:0] imm_o,
  output logic [4:0]        shamt_o
);

  import rv_pkg::*;

  rv_insn_u           in_view;
  rv_insn_u           q_view;
  logic signed [31:0] imm_c;

  logic               valid_q;
  logic [AWIDTH-1:0]  pc_q;
  logic [DWIDTH-1:0]  insn_q;
  logic [DWIDTH-1:0]  imm_q;

  assign in_view = insn_i[31:0];

  // Immediate format chosen by opcode
  always_comb begin
    imm_c = '0;
    case (in_view.r.opcode)
      OP_IMM, OP_LOAD, OP_JALR: begin
        imm_c = {{20{in_view.i.imm_11_0[11]}}, in_view.i.imm_11_0};
      end
      OP_STORE: begin
        imm_c = {{20{in_view.s.imm_11_5[6]}}, in_view.s.imm_11_5, in_view.s.imm_4_0};
      end
      OP_BRANCH: begin
        imm_c = {{19{in_view.b.imm_12}}, in_view.b.imm_12, in_view.b.imm_11,
                 in_view.b.imm_10_5, in_view.b.imm_4_1, 1'b0};
      end
      OP_LUI, OP_AUIPC: begin
        imm_c = {in_view.u.imm_31_12, 12'b0};
      end
      OP_JAL: begin
        imm_c = {{11{in_view.j.imm_20}}, in_view.j.imm_20, in_view.j.imm_19_12,
                 in_view.j.imm_11, in_view.j.imm_10_1, 1'b0};
      end
      // R-type has no immediate
      default: begin
        imm_c = '0;
      end
    endcase
  end

  // Decode-stage register, cleared so that opcode 0 reads as illegal
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      pc_q    <= '0;
      insn_q  <= '0;
      imm_q   <= '0;
    end else begin
      valid_q <= valid_i;
      if (valid_i) begin
        pc_q   <= pc_i;
        insn_q <= insn_i;
        imm_q  <= DWIDTH'(imm_c);
      end
    end
  end

  // Register fields sit at fixed bit positions
  assign q_view   = insn_q[31:0];
  assign valid_o  = valid_q;
  assign pc_o     = pc_q;
  assign insn_o   = insn_q;
  assign opcode_o = q_view.r.opcode;
  assign rd_o     = q_view.r.rd;
  assign rs1_o    = q_view.r.rs1;
  assign rs2_o    = q_view.r.rs2;
  assign funct3_o = q_view.r.funct3;
  assign funct7_o = q_view.r.funct7;
  assign imm_o    = imm_q;
  // Bits 24:20
  assign shamt_o  = q_view.i.imm_11_0[4:0];

endmodule

/* logic/control.sv */
//########################################
// Purely combinational control word
// Unknown opcodes give all selects zero
//########################################

`timescale 1ns/1ns

module control (
  input  logic [6:0]       opcode_i,
  input  logic [2:0]       funct3_i,
  input  logic [6:0]       funct7_i,
  output logic             pcsel_o,
  output logic             immsel_o,
  output logic             regwren_o,
  output logic             rs1sel_o,
  output logic             rs2sel_o,
  output logic             memren_o,
  output logic             memwren_o,
  output rv_pkg::wb_sel_e  wbsel_o,
  output rv_pkg::alu_sel_e alusel_o
);

  import rv_pkg::*;

  // ALU operation of the register and immediate arithmetic groups
  function automatic alu_sel_e arith_op(input logic [2:0] f3, input logic f7b5,
                                        input logic is_reg);
    alu_sel_e op;
    case (f3)
      3'd0:    op = (is_reg && f7b5) ? ALU_SUB : ALU_ADD;
      3'd1:    op = ALU_SLL;
      3'd2:    op = ALU_SLT;
      3'd3:    op = ALU_SLTU;
      3'd4:    op = ALU_XOR;
      3'd5:    op = f7b5 ? ALU_SRA : ALU_SRL;
      3'd6:    op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    pcsel_o   = 1'b0;
    immsel_o  = 1'b0;
    regwren_o = 1'b0;
    rs1sel_o  = 1'b0;
    rs2sel_o  = 1'b0;
    memren_o  = 1'b0;
    memwren_o = 1'b0;
    wbsel_o   = WB_ALU;
    alusel_o  = ALU_ADD;
    case (opcode_i)
      OP_LUI: begin
        immsel_o  = 1'b1;
        regwren_o = 1'b1;
        rs2sel_o  = 1'b1;
        alusel_o  = ALU_PASS_B;
      end
      OP_AUIPC: begin
        immsel_o  = 1'b1;
        regwren_o = 1'b1;
        rs1sel_o  = 1'b1;
        rs2sel_o  = 1'b1;
      end
      OP_JAL: begin
        pcsel_o   = 1'b1;
        immsel_o  = 1'b1;
        regwren_o = 1'b1;
        rs1sel_o  = 1'b1;
        rs2sel_o  = 1'b1;
        wbsel_o   = WB_PC4;
      end
      OP_JALR: begin
        pcsel_o   = 1'b1;
        immsel_o  = 1'b1;
        regwren_o = 1'b1;
        rs2sel_o  = 1'b1;
        wbsel_o   = WB_PC4;
      end
      // Target is PC plus offset
      OP_BRANCH: begin
        pcsel_o  = 1'b1;
        immsel_o = 1'b1;
        rs1sel_o = 1'b1;
        rs2sel_o = 1'b1;
      end
      OP_LOAD: begin
        immsel_o  = 1'b1;
        regwren_o = 1'b1;
        rs2sel_o  = 1'b1;
        memren_o  = 1'b1;
        wbsel_o   = WB_MEM;
      end
      OP_STORE: begin
        immsel_o  = 1'b1;
        rs2sel_o  = 1'b1;
        memwren_o = 1'b1;
      end
      OP_IMM: begin
        immsel_o  = 1'b1;
        regwren_o = 1'b1;
        rs2sel_o  = 1'b1;
        alusel_o  = arith_op(funct3_i, funct7_i[5], 1'b0);
      end
      OP_REG: begin
        regwren_o = 1'b1;
        alusel_o  = arith_op(funct3_i, funct7_i[5], 1'b1);
      end
      default: begin
        // Unknown opcode keeps every select at zero
      end
    endcase
  end

endmodule

/* logic/pd2.sv */
//########################################
// Front end only: fetch, decode, control
// Load memory while run_i is low
//########################################

`timescale 1ns/1ns

module pd2 #(
  parameter int                AWIDTH    = 32,
  parameter int                DWIDTH    = 32,
  parameter logic [AWIDTH-1:0] BASE_ADDR = 32'h0100_0000,
  parameter int                MEM_DEPTH = 256
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              run_i,
  input  logic              load_en_i,
  input  logic [AWIDTH-1:0] load_addr_i,
  input  logic [DWIDTH-1:0] load_data_i,
  output logic              f_valid_o,
  output logic [AWIDTH-1:0] f_pc_o,
  output logic [DWIDTH-1:0] f_insn_o,
  output logic              d_valid_o,
  output logic [AWIDTH-1:0] d_pc_o,
  output logic [DWIDTH-1:0] d_insn_o,
  output logic [6:0]        d_opcode_o,
  output logic [4:0]        d_rd_o,
  output logic [4:0]        d_rs1_o,
  output logic [4:0]        d_rs2_o,
  output logic [2:0]        d_funct3_o,
  output logic [6:0]        d_funct7_o,
  output logic [DWIDTH-1:0] d_imm_o,
  output logic [4:0]        d_shamt_o,
  output logic              pcsel_o,
  output logic              immsel_o,
  output logic              regwren_o,
  output logic              rs1sel_o,
  output logic              rs2sel_o,
  output logic              memren_o,
  output logic              memwren_o,
  output rv_pkg::wb_sel_e   wbsel_o,
  output rv_pkg::alu_sel_e  alusel_o
);

  logic [AWIDTH-1:0] fetch_pc;
  logic [DWIDTH-1:0] mem_rdata;

  insn_memory #(
    .AWIDTH   (AWIDTH),
    .DWIDTH   (DWIDTH),
    .BASE_ADDR(BASE_ADDR),
    .MEM_DEPTH(MEM_DEPTH)
  ) insn_memory_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .addr_i      (fetch_pc),
    .data_i      (load_data_i),
    .read_en_i   (run_i),
    .write_en_i  (load_en_i),
    .write_addr_i(load_addr_i),
    .data_o      (mem_rdata)
  );

  fetch #(
    .AWIDTH   (AWIDTH),
    .DWIDTH   (DWIDTH),
    .BASE_ADDR(BASE_ADDR)
  ) fetch_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .run_i    (run_i),
    .insn_i   (mem_rdata),
    .pc_o     (fetch_pc),
    .f_valid_o(f_valid_o),
    .f_pc_o   (f_pc_o),
    .f_insn_o (f_insn_o)
  );

  decode #(
    .AWIDTH(AWIDTH),
    .DWIDTH(DWIDTH)
  ) decode_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (f_valid_o),
    .pc_i    (f_pc_o),
    .insn_i  (f_insn_o),
    .valid_o (d_valid_o),
    .pc_o    (d_pc_o),
    .insn_o  (d_insn_o),
    .opcode_o(d_opcode_o),
    .rd_o    (d_rd_o),
    .rs1_o   (d_rs1_o),
    .rs2_o   (d_rs2_o),
    .funct3_o(d_funct3_o),
    .funct7_o(d_funct7_o),
    .imm_o   (d_imm_o),
    .shamt_o (d_shamt_o)
  );

  // Control sees the decode-stage fields in the same cycle
  control control_inst (
    .opcode_i (d_opcode_o),
    .funct3_i (d_funct3_o),
    .funct7_i (d_funct7_o),
    .pcsel_o  (pcsel_o),
    .immsel_o (immsel_o),
    .regwren_o(regwren_o),
    .rs1sel_o (rs1sel_o),
    .rs2sel_o (rs2sel_o),
    .memren_o (memren_o),
    .memwren_o(memwren_o),
    .wbsel_o  (wbsel_o),
    .alusel_o (alusel_o)
  );

endmodule

/* bench/pd2_tb.sv */
//########################################
// Directed tests for the pd2 front end
// Expected values come from the RV32I rules
// Memory is loaded while run_i is low
//########################################

`timescale 1ns/1ns

module pd2_tb;

  import rv_pkg::*;

  localparam int                AWIDTH    = 32;
  localparam int                DWIDTH    = 32;
  localparam logic [AWIDTH-1:0] BASE_ADDR = 32'h0100_0000;
  localparam int                MEM_DEPTH = 256;

  logic              clk;
  logic              rst_n_i;
  logic              run_i;
  logic              load_en_i;
  logic [AWIDTH-1:0] load_addr_i;
  logic [DWIDTH-1:0] load_data_i;
  logic              f_valid_o;
  logic [AWIDTH-1:0] f_pc_o;
  logic [DWIDTH-1:0] f_insn_o;
  logic              d_valid_o;
  logic [AWIDTH-1:0] d_pc_o;
  logic [DWIDTH-1:0] d_insn_o;
  logic [6:0]        d_opcode_o;
  logic [4:0]        d_rd_o;
  logic [4:0]        d_rs1_o;
  logic [4:0]        d_rs2_o;
  logic [2:0]        d_funct3_o;
  logic [6:0]        d_funct7_o;
  logic [DWIDTH-1:0] d_imm_o;
  logic [4:0]        d_shamt_o;
  logic              pcsel_o;
  logic              immsel_o;
  logic              regwren_o;
  logic              rs1sel_o;
  logic              rs2sel_o;
  logic              memren_o;
  logic              memwren_o;
  wb_sel_e           wbsel_o;
  alu_sel_e          alusel_o;

  // Program image and the fetch and decode samples of one run
  logic [31:0] prog [MEM_DEPTH];
  logic [31:0] cap_fpc[$];
  logic [31:0] cap_finsn[$];
  logic [31:0] cap_pc[$];
  logic [31:0] cap_insn[$];
  logic [31:0] cap_fields[$];
  logic [31:0] cap_imm[$];
  logic [4:0]  cap_shamt[$];
  logic [12:0] cap_ctrl[$];

  logic [31:0] rng_state;
  int          errors;
  int          tests_run;
  int          tests_failed;

  pd2 #(
    .AWIDTH   (AWIDTH),
    .DWIDTH   (DWIDTH),
    .BASE_ADDR(BASE_ADDR),
    .MEM_DEPTH(MEM_DEPTH)
  ) pd2_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .run_i      (run_i),
    .load_en_i  (load_en_i),
    .load_addr_i(load_addr_i),
    .load_data_i(load_data_i),
    .f_valid_o  (f_valid_o),
    .f_pc_o     (f_pc_o),
    .f_insn_o   (f_insn_o),
    .d_valid_o  (d_valid_o),
    .d_pc_o     (d_pc_o),
    .d_insn_o   (d_insn_o),
    .d_opcode_o (d_opcode_o),
    .d_rd_o     (d_rd_o),
    .d_rs1_o    (d_rs1_o),
    .d_rs2_o    (d_rs2_o),
    .d_funct3_o (d_funct3_o),
    .d_funct7_o (d_funct7_o),
    .d_imm_o    (d_imm_o),
    .d_shamt_o  (d_shamt_o),
    .pcsel_o    (pcsel_o),
    .immsel_o   (immsel_o),
    .regwren_o  (regwren_o),
    .rs1sel_o   (rs1sel_o),
    .rs2sel_o   (rs2sel_o),
    .memren_o   (memren_o),
    .memwren_o  (memwren_o),
    .wbsel_o    (wbsel_o),
    .alusel_o   (alusel_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [6:0] pick_opcode(input logic [31:0] r);
    case (int'(r % 32'd9))
      0: return OP_LUI;
      1: return OP_AUIPC;
      2: return OP_JAL;
      3: return OP_JALR;
      4: return OP_BRANCH;
      5: return OP_LOAD;
      6: return OP_STORE;
      7: return OP_IMM;
      default: return OP_REG;
    endcase
  endfunction

  // Random upper bits over a legal major opcode
  function automatic logic [31:0] random_insn();
    logic [31:0] r;
    r = next_random();
    return {r[31:7], pick_opcode(next_random())};
  endfunction

  function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    rv_insn_u u;
    u.r.funct7 = f7;
    u.r.rs2    = rs2;
    u.r.rs1    = rs1;
    u.r.funct3 = f3;
    u.r.rd     = rd;
    u.r.opcode = op;
    return u;
  endfunction

  function automatic logic [31:0] make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    rv_insn_u u;
    u.i.imm_11_0 = imm;
    u.i.rs1      = rs1;
    u.i.funct3   = f3;
    u.i.rd       = rd;
    u.i.opcode   = op;
    return u;
  endfunction

  function automatic logic [31:0] make_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    rv_insn_u u;
    u.s.imm_11_5 = imm[11:5];
    u.s.rs2      = rs2;
    u.s.rs1      = rs1;
    u.s.funct3   = f3;
    u.s.imm_4_0  = imm[4:0];
    u.s.opcode   = OP_STORE;
    return u;
  endfunction

  function automatic logic [31:0] make_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    rv_insn_u u;
    u.b.imm_12   = imm[12];
    u.b.imm_10_5 = imm[10:5];
    u.b.rs2      = rs2;
    u.b.rs1      = rs1;
    u.b.funct3   = f3;
    u.b.imm_4_1  = imm[4:1];
    u.b.imm_11   = imm[11];
    u.b.opcode   = OP_BRANCH;
    return u;
  endfunction

  function automatic logic [31:0] make_u(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    rv_insn_u u;
    u.u.imm_31_12 = imm;
    u.u.rd        = rd;
    u.u.opcode    = op;
    return u;
  endfunction

  function automatic logic [31:0] make_j(input logic [20:0] imm, input logic [4:0] rd);
    rv_insn_u u;
    u.j.imm_20    = imm[20];
    u.j.imm_10_1  = imm[10:1];
    u.j.imm_11    = imm[11];
    u.j.imm_19_12 = imm[19:12];
    u.j.rd        = rd;
    u.j.opcode    = OP_JAL;
    return u;
  endfunction

  // Reference immediate from the ISA bit positions
  function automatic logic [31:0] ref_imm(input logic [31:0] w);
    case (w[6:0])
      OP_IMM, OP_LOAD, OP_JALR: return {{20{w[31]}}, w[31:20]};
      OP_STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
      OP_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      OP_LUI, OP_AUIPC: return {w[31:12], 12'b0};
      OP_JAL: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: return 32'h0;
    endcase
  endfunction

  // Control word packed as pcsel..memwren, wbsel, alusel
  function automatic logic [12:0] ref_ctrl(input logic [31:0] w);
    logic [6:0] op;
    logic       f7b5;
    logic       known;
    wb_sel_e    wb;
    alu_sel_e   alu;
    op    = w[6:0];
    f7b5  = w[30];
    known = (op == OP_LUI) || (op == OP_AUIPC) || (op == OP_JAL) || (op == OP_JALR) ||
            (op == OP_BRANCH) || (op == OP_LOAD) || (op == OP_STORE) ||
            (op == OP_IMM) || (op == OP_REG);
    wb  = (op == OP_LOAD) ? WB_MEM : ((op == OP_JAL) || (op == OP_JALR)) ? WB_PC4 : WB_ALU;
    alu = (op == OP_LUI) ? ALU_PASS_B : ALU_ADD;
    if ((op == OP_REG) || (op == OP_IMM)) begin
      case (w[14:12])
        3'd0: alu = ((op == OP_REG) && f7b5) ? ALU_SUB : ALU_ADD;
        3'd1: alu = ALU_SLL;
        3'd2: alu = ALU_SLT;
        3'd3: alu = ALU_SLTU;
        3'd4: alu = ALU_XOR;
        3'd5: alu = f7b5 ? ALU_SRA : ALU_SRL;
        3'd6: alu = ALU_OR;
        default: alu = ALU_AND;
      endcase
    end
    return {(op == OP_JAL) || (op == OP_JALR) || (op == OP_BRANCH),
            known && (op != OP_REG),
            known && (op != OP_BRANCH) && (op != OP_STORE),
            (op == OP_AUIPC) || (op == OP_JAL) || (op == OP_BRANCH),
            known && (op != OP_REG),
            op == OP_LOAD,
            op == OP_STORE,
            wb, alu};
  endfunction

  task automatic compare_value(input string test, input string what, input int idx,
                               input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s: %s of entry %0d expected 0x%h, actual 0x%h",
               test, what, idx, exp, act);
      errors++;
    end
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    run_i   = 1'b0;
    repeat (16) @(negedge clk);
    rst_n_i = 1'b1;
  endtask

  task automatic load_program(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      load_en_i   = 1'b1;
      load_addr_i = BASE_ADDR + (32'(i) << 2);
      load_data_i = prog[i];
    end
    @(negedge clk);
    load_en_i = 1'b0;
  endtask

  // Issues count fetches, with run_i low for stall_len cycles after stall_at issues
  task automatic run_and_collect(input string test, input int count, input int stall_at,
                                 input int stall_len);
    int issued;
    int idle;
    int cycles;
    int limit;
    cap_fpc.delete();
    cap_finsn.delete();
    cap_pc.delete();
    cap_insn.delete();
    cap_fields.delete();
    cap_imm.delete();
    cap_shamt.delete();
    cap_ctrl.delete();
    issued = 0;
    idle   = 0;
    cycles = 0;
    limit  = count + stall_len + 16;
    while ((cap_pc.size() < count) && (cycles < limit)) begin
      @(negedge clk);
      if (f_valid_o === 1'b1) begin
        cap_fpc.push_back(f_pc_o);
        cap_finsn.push_back(f_insn_o);
      end
      if (d_valid_o === 1'b1) begin
        cap_pc.push_back(d_pc_o);
        cap_insn.push_back(d_insn_o);
        cap_fields.push_back({d_funct7_o, d_rs2_o, d_rs1_o, d_funct3_o, d_rd_o, d_opcode_o});
        cap_imm.push_back(d_imm_o);
        cap_shamt.push_back(d_shamt_o);
        cap_ctrl.push_back({pcsel_o, immsel_o, regwren_o, rs1sel_o, rs2sel_o, memren_o,
                            memwren_o, wbsel_o, alusel_o});
      end
      if ((issued < count) && !((issued == stall_at) && (idle < stall_len))) begin
        run_i = 1'b1;
        issued++;
      end else begin
        run_i = 1'b0;
        if (issued == stall_at) idle++;
      end
      cycles++;
    end
    run_i = 1'b0;
    if (cap_pc.size() < count) begin
      $display("%s: timed out with %0d of %0d decoded instructions seen",
               test, cap_pc.size(), count);
      errors++;
    end
  endtask

  task automatic check_capture(input string test, input int idx, input logic [31:0] w);
    compare_value(test, "f_pc", idx, BASE_ADDR + (32'(idx) << 2), cap_fpc[idx]);
    compare_value(test, "f_insn", idx, w, cap_finsn[idx]);
    compare_value(test, "d_pc", idx, BASE_ADDR + (32'(idx) << 2), cap_pc[idx]);
    compare_value(test, "d_insn", idx, w, cap_insn[idx]);
    // Every field is a raw slice, so they match the word bit for bit
    compare_value(test, "fields", idx, w, cap_fields[idx]);
    compare_value(test, "d_imm", idx, ref_imm(w), cap_imm[idx]);
    compare_value(test, "d_shamt", idx, 32'(w[24:20]), 32'(cap_shamt[idx]));
    compare_value(test, "control", idx, 32'(ref_ctrl(w)), 32'(cap_ctrl[idx]));
  endtask

  task automatic check_run(input string test, input int count);
    for (int i = 0; (i < count) && (i < cap_pc.size()); i++) begin
      check_capture(test, i, prog[i % MEM_DEPTH]);
    end
  endtask

  task automatic report_test(input string test, input int errs_before);
    tests_run++;
    if (errors > errs_before) begin
      tests_failed++;
      $display("FAIL %s (%0d errors)", test, errors - errs_before);
    end else begin
      $display("PASS %s", test);
    end
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    apply_reset();
    repeat (2) begin
      @(negedge clk);
      compare_value("reset_state", "f_valid", 0, 32'h0, 32'(f_valid_o));
      compare_value("reset_state", "d_valid", 0, 32'h0, 32'(d_valid_o));
      compare_value("reset_state", "control", 0, 32'h0,
                    32'({pcsel_o, immsel_o, regwren_o, rs1sel_o, rs2sel_o, memren_o,
                         memwren_o, wbsel_o, alusel_o}));
    end
    report_test("reset_state", e0);
  endtask

  task automatic test_sequential_fetch();
    int e0;
    e0 = errors;
    apply_reset();
    for (int i = 0; i < 8; i++) prog[i] = random_insn();
    load_program(8);
    run_and_collect("sequential_fetch", 8, -1, 0);
    check_run("sequential_fetch", 8);
    report_test("sequential_fetch", e0);
  endtask

  task automatic test_fields_imm();
    int e0;
    e0 = errors;
    apply_reset();
    prog[0]  = make_r(7'h20, 5'd3, 5'd2, 3'd0, 5'd1, OP_REG);
    prog[1]  = make_i(12'hffb, 5'd4, 3'd0, 5'd5, OP_IMM);
    prog[2]  = make_i(12'h123, 5'd6, 3'd0, 5'd7, OP_IMM);
    // SRAI by 31
    prog[3]  = make_i(12'h41f, 5'd8, 3'd5, 5'd9, OP_IMM);
    prog[4]  = make_i(12'h800, 5'd10, 3'd2, 5'd11, OP_LOAD);
    prog[5]  = make_i(12'h7ff, 5'd12, 3'd0, 5'd13, OP_JALR);
    prog[6]  = make_s(12'hff0, 5'd14, 5'd15, 3'd2);
    prog[7]  = make_s(12'h07c, 5'd16, 5'd17, 3'd0);
    prog[8]  = make_b(13'h1ff8, 5'd18, 5'd19, 3'd1);
    prog[9]  = make_b(13'h0ffe, 5'd20, 5'd21, 3'd4);
    prog[10] = make_u(20'hfffff, 5'd22, OP_LUI);
    prog[11] = make_u(20'h12345, 5'd23, OP_AUIPC);
    prog[12] = make_j(21'h1ffffc, 5'd1);
    prog[13] = make_j(21'h0abcde, 5'd24);
    load_program(14);
    run_and_collect("fields_imm", 14, -1, 0);
    check_run("fields_imm", 14);
    report_test("fields_imm", e0);
  endtask

  task automatic test_control_table();
    int e0;
    int n;
    e0 = errors;
    apply_reset();
    prog[0] = make_u(20'h0abcd, 5'd1, OP_LUI);
    prog[1] = make_u(20'h80001, 5'd2, OP_AUIPC);
    prog[2] = make_j(21'h000010, 5'd3);
    prog[3] = make_i(12'h004, 5'd4, 3'd0, 5'd5, OP_JALR);
    prog[4] = make_b(13'h0008, 5'd6, 5'd7, 3'd0);
    prog[5] = make_i(12'h010, 5'd8, 3'd2, 5'd9, OP_LOAD);
    prog[6] = make_s(12'h020, 5'd10, 5'd11, 3'd2);
    n = 7;
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int hi = 0; hi < 2; hi++) begin
        prog[n]     = make_r((hi != 0) ? 7'h20 : 7'h00, 5'd1, 5'd2, 3'(f3), 5'd3, OP_REG);
        prog[n + 1] = make_i({(hi != 0) ? 7'h20 : 7'h00, 5'd7}, 5'd2, 3'(f3), 5'd3, OP_IMM);
        n += 2;
      end
    end
    // Opcode outside RV32I
    prog[n] = make_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'h7f);
    n++;
    load_program(n);
    run_and_collect("control_table", n, -1, 0);
    check_run("control_table", n);
    report_test("control_table", e0);
  endtask

  task automatic test_stall();
    int e0;
    e0 = errors;
    apply_reset();
    for (int i = 0; i < 12; i++) prog[i] = random_insn();
    load_program(12);
    run_and_collect("stall", 12, 5, 3);
    check_run("stall", 12);
    // Pipeline is empty two edges after run_i drops
    repeat (3) begin
      @(negedge clk);
      if (d_valid_o === 1'b1) begin
        $display("stall: extra decoded instruction at pc 0x%h after the program", d_pc_o);
        errors++;
      end
    end
    report_test("stall", e0);
  endtask

  task automatic test_random_wrap();
    int e0;
    e0 = errors;
    apply_reset();
    for (int i = 0; i < MEM_DEPTH; i++) prog[i] = random_insn();
    load_program(MEM_DEPTH);
    run_and_collect("random_wrap", MEM_DEPTH + 4, -1, 0);
    check_run("random_wrap", MEM_DEPTH + 4);
    if (cap_pc.size() > MEM_DEPTH) begin
      compare_value("random_wrap", "wrap pc", MEM_DEPTH,
                    BASE_ADDR + 32'(4 * MEM_DEPTH), cap_pc[MEM_DEPTH]);
      compare_value("random_wrap", "wrap insn", MEM_DEPTH, prog[0], cap_insn[MEM_DEPTH]);
    end
    report_test("random_wrap", e0);
  endtask

  // Last-resort guard against a hung run
  initial begin
    #(20 * 50000);
    $display("Simulation did not finish within 50000 cycles");
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst_n_i      = 1'b0;
    run_i        = 1'b0;
    load_en_i    = 1'b0;
    load_addr_i  = '0;
    load_data_i  = '0;
    rng_state    = 32'ha5cc_6172;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_reset_state();
    test_sequential_fetch();
    test_fields_imm();
    test_control_table();
    test_stall();
    test_random_wrap();
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* files.f */
logic/rv_pkg.sv
logic/insn_memory.sv
logic/fetch.sv
logic/decode.sv
logic/control.sv
logic/pd2.sv
bench/pd2_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= pd2_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
